/* axi_mem_pkg.sv */
package axi_mem_pkg;

    //----------------------------------------------------------------------
    // Bus widths
    //----------------------------------------------------------------------
    localparam int ADDR_WIDTH = 32;             // Byte address
    localparam int WORD_BYTES = 4;              // Bytes per memory word

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [3:0]            len_t;       // Beats minus one
    typedef logic [31:0]           word_t;
    typedef logic [1:0]            resp_t;

    //----------------------------------------------------------------------
    // Encodings
    //----------------------------------------------------------------------
    localparam resp_t RESP_OKAY = 2'b00;

    // AXI3 burst type field
    typedef enum logic [1:0] {
        BURST_FIXED    = 2'b00,
        BURST_INCR     = 2'b01,
        BURST_WRAP     = 2'b10,
        BURST_RESERVED = 2'b11                  // Treated as FIXED
    } burst_e;

endpackage

/* axi_cmd_fifo.sv */
`timescale 1ns/1ps

module axi_cmd_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16                    // Power of two
) (
    input  logic             ACLK,
    input  logic             ARESETn,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             full,
    output logic             empty
);

    localparam int PW = $clog2(DEPTH);

    logic [WIDTH-1:0] store [DEPTH];
    logic [PW:0]      wr_ptr;                   // Top bit is the wrap flag
    logic [PW:0]      rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);

    // Overflow and underflow requests are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head = store[rd_ptr[PW-1:0]];

    always_ff @(posedge ACLK) begin
        if (do_push) begin
            store[wr_ptr[PW-1:0]] <= push_data;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* axi_burst_addr.sv */
`timescale 1ns/1ps

module axi_burst_addr #(
    parameter int DATA_WIDTH = 128
) (
    input  axi_mem_pkg::addr_t  addr,           // Start address of the burst
    input  axi_mem_pkg::len_t   len,
    input  axi_mem_pkg::burst_e burst,
    input  axi_mem_pkg::len_t   beat,           // Beat number within the burst
    output axi_mem_pkg::addr_t  beat_addr
);

    import axi_mem_pkg::*;

    localparam int LSB = $clog2(DATA_WIDTH / 8);    // Byte offset bits of a beat

    addr_t      aligned;
    logic [3:0] start_idx;
    logic [3:0] wrap_idx;
    logic       wrap_ok;

    assign aligned   = {addr[ADDR_WIDTH-1:LSB], {LSB{1'b0}}};
    assign start_idx = addr[LSB +: 4];

    // Window of len+1 beats, so len itself is the index mask
    assign wrap_ok  = (len == 4'd1) || (len == 4'd3) || (len == 4'd7) || (len == 4'd15);
    assign wrap_idx = (start_idx & ~len) | ((start_idx + beat) & len);

    always_comb begin
        case (burst)
            BURST_INCR: beat_addr = aligned + (addr_t'(beat) << LSB);
            BURST_WRAP: begin
                if (wrap_ok) begin
                    beat_addr = {addr[ADDR_WIDTH-1:LSB+4], wrap_idx, {LSB{1'b0}}};
                end else begin
                    beat_addr = aligned;        // Odd length falls back to FIXED
                end
            end
            default:    beat_addr = aligned;    // FIXED and reserved code
        endcase
    end

endmodule

/* axi_mem_array.sv */
`timescale 1ns/1ps

module axi_mem_array #(
    parameter int DATA_WIDTH = 128,
    parameter int MEM_WORDS  = 1024             // Power of two
) (
    input  logic                    ACLK,
    input  axi_mem_pkg::addr_t      rd_addr,
    output logic [DATA_WIDTH-1:0]   rd_data,
    input  logic                    wr_en,
    input  axi_mem_pkg::addr_t      wr_addr,
    input  logic [DATA_WIDTH-1:0]   wr_data,
    input  logic [DATA_WIDTH/8-1:0] wr_strb
);

    import axi_mem_pkg::*;

    localparam int WORD_W = WORD_BYTES * 8;
    localparam int LANES  = DATA_WIDTH / WORD_W;
    localparam int IDX_W  = $clog2(MEM_WORDS);
    localparam int OFS_W  = $clog2(WORD_BYTES);

    word_t            mem [MEM_WORDS] = '{default: '0};
    logic [IDX_W-1:0] rd_base;
    logic [IDX_W-1:0] wr_base;

    // Word index wraps at the memory size
    assign rd_base = rd_addr[OFS_W +: IDX_W];
    assign wr_base = wr_addr[OFS_W +: IDX_W];

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            rd_data[k*WORD_W +: WORD_W] = mem[rd_base + IDX_W'(k)];
        end
    end

    // Strobe bit j goes to byte j%4 of lane j/4
    always_ff @(posedge ACLK) begin
        for (int k = 0; k < LANES; k++) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (wr_en && wr_strb[k*WORD_BYTES + b]) begin
                    mem[wr_base + IDX_W'(k)][b*8 +: 8] <= wr_data[(k*WORD_BYTES + b)*8 +: 8];
                end
            end
        end
    end

endmodule

/* axi_read_channel.sv */
`timescale 1ns/1ps

module axi_read_channel #(
    parameter int DATA_WIDTH = 128,
    parameter int ID_WIDTH   = 8
) (
    input  logic                  ACLK,
    input  logic                  ARESETn,
    input  logic                  rd_bus_hold,
    // Head of the read command queue
    input  logic                  cmd_empty,
    input  axi_mem_pkg::addr_t    cmd_addr,
    input  axi_mem_pkg::len_t     cmd_len,
    input  axi_mem_pkg::burst_e   cmd_burst,
    input  logic [ID_WIDTH-1:0]   cmd_id,
    output logic                  cmd_pop,
    // Memory read port
    output axi_mem_pkg::addr_t    mem_rd_addr,
    input  logic [DATA_WIDTH-1:0] mem_rd_data,
    // R channel
    input  logic                  rready,
    output logic                  rvalid,
    output logic [ID_WIDTH-1:0]   rid,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  rlast,
    output axi_mem_pkg::resp_t    rresp
);

    import axi_mem_pkg::*;

    len_t beat_cnt;
    logic r_beat;

    assign rvalid  = !cmd_empty && !rd_bus_hold;
    assign rlast   = rvalid && (beat_cnt == cmd_len);
    assign r_beat  = rvalid && rready;
    assign cmd_pop = r_beat && rlast;           // Retire command on final beat

    assign rid   = cmd_id;
    assign rdata = mem_rd_data;
    assign rresp = RESP_OKAY;

    axi_burst_addr #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_rd_addr (
        .addr      (cmd_addr),
        .len       (cmd_len),
        .burst     (cmd_burst),
        .beat      (beat_cnt),
        .beat_addr (mem_rd_addr)
    );

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            beat_cnt <= '0;
        end else if (r_beat) begin
            beat_cnt <= rlast ? '0 : beat_cnt + 1'b1;
        end
    end

endmodule

/* axi_write_channel.sv */
`timescale 1ns/1ps

module axi_write_channel #(
    parameter int DATA_WIDTH = 128,
    parameter int ID_WIDTH   = 8,
    parameter int ACAPA      = 16
) (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    input  logic                    wr_bus_hold,
    input  logic                    br_bus_hold,
    // Head of the write command queue
    input  logic                    cmd_empty,
    input  axi_mem_pkg::addr_t      cmd_addr,
    input  axi_mem_pkg::len_t       cmd_len,
    input  axi_mem_pkg::burst_e     cmd_burst,
    input  logic [ID_WIDTH-1:0]     cmd_id,
    output logic                    cmd_pop,
    // Memory write port
    output logic                    mem_wr_en,
    output axi_mem_pkg::addr_t      mem_wr_addr,
    output logic [DATA_WIDTH-1:0]   mem_wr_data,
    output logic [DATA_WIDTH/8-1:0] mem_wr_strb,
    // W channel
    input  logic                    wvalid,
    input  logic [DATA_WIDTH-1:0]   wdata,
    input  logic [DATA_WIDTH/8-1:0] wstrb,
    input  logic                    wlast,
    output logic                    wready,
    // B channel
    input  logic                    bready,
    output logic                    bvalid,
    output logic [ID_WIDTH-1:0]     bid,
    output axi_mem_pkg::resp_t      bresp
);

    import axi_mem_pkg::*;

    len_t beat_cnt;
    logic w_beat;
    logic rsp_full;
    logic rsp_empty;

    // No data accepted without an address or a free response slot
    assign wready  = !cmd_empty && !rsp_full && !wr_bus_hold;
    assign w_beat  = wvalid && wready;
    assign cmd_pop = w_beat && wlast;

    assign mem_wr_en   = w_beat;
    assign mem_wr_data = wdata;
    assign mem_wr_strb = wstrb;

    assign bvalid = !rsp_empty && !br_bus_hold;
    assign bresp  = RESP_OKAY;

    axi_burst_addr #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_wr_addr (
        .addr      (cmd_addr),
        .len       (cmd_len),
        .burst     (cmd_burst),
        .beat      (beat_cnt),
        .beat_addr (mem_wr_addr)
    );

    // IDs waiting for their response, in completion order
    axi_cmd_fifo #(
        .WIDTH (ID_WIDTH),
        .DEPTH (ACAPA)
    ) u_rsp_fifo (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .push      (cmd_pop),
        .push_data (cmd_id),
        .pop       (bvalid && bready),
        .head      (bid),
        .full      (rsp_full),
        .empty     (rsp_empty)
    );

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            beat_cnt <= '0;
        end else if (w_beat) begin
            if (wlast) begin
                beat_cnt <= '0;
            end else if (beat_cnt != cmd_len) begin
                beat_cnt <= beat_cnt + 1'b1;    // Saturates if wlast is late
            end
        end
    end

endmodule

/* axi_slave_mem.sv */
`timescale 1ns/1ps

module axi_slave_mem #(
    parameter int DATA_WIDTH = 128,             // 64, 128 or 256
    parameter int ID_WIDTH   = 8,
    parameter int ACAPA      = 16,              // Outstanding commands per direction
    parameter int MEM_WORDS  = 1024
) (
    input  logic                    ACLK,
    input  logic                    ARESETn,

    input  logic                    rd_bus_hold,
    input  logic                    wr_bus_hold,
    input  logic                    br_bus_hold,

    // Read address
    output logic                    arready,
    input  logic                    arvalid,
    input  logic [ID_WIDTH-1:0]     arid,
    input  axi_mem_pkg::addr_t      araddr,
    input  axi_mem_pkg::len_t       arlen,
    input  axi_mem_pkg::burst_e     arburst,

    // Read data
    input  logic                    rready,
    output logic                    rvalid,
    output logic [ID_WIDTH-1:0]     rid,
    output logic [DATA_WIDTH-1:0]   rdata,
    output logic                    rlast,
    output axi_mem_pkg::resp_t      rresp,

    // Write address
    output logic                    awready,
    input  logic                    awvalid,
    input  logic [ID_WIDTH-1:0]     awid,
    input  axi_mem_pkg::addr_t      awaddr,
    input  axi_mem_pkg::len_t       awlen,
    input  axi_mem_pkg::burst_e     awburst,

    // Write data
    output logic                    wready,
    input  logic                    wvalid,
    input  logic [DATA_WIDTH-1:0]   wdata,
    input  logic [DATA_WIDTH/8-1:0] wstrb,
    input  logic                    wlast,

    // Write response
    input  logic                    bready,
    output logic                    bvalid,
    output axi_mem_pkg::resp_t      bresp,
    output logic [ID_WIDTH-1:0]     bid
);

    import axi_mem_pkg::*;

    //----------------------------------------------------------------------
    // Command layout in the queues: {burst, addr, len, id}
    //----------------------------------------------------------------------
    localparam int LEN_LSB   = ID_WIDTH;
    localparam int ADDR_LSB  = LEN_LSB + $bits(len_t);
    localparam int BURST_LSB = ADDR_LSB + ADDR_WIDTH;
    localparam int CMD_W     = BURST_LSB + $bits(burst_e);

    logic [CMD_W-1:0]        rd_head;
    logic [CMD_W-1:0]        wr_head;
    logic                    rd_full;
    logic                    rd_empty;
    logic                    rd_pop;
    logic                    wr_full;
    logic                    wr_empty;
    logic                    wr_pop;
    addr_t                   mem_rd_addr;
    logic [DATA_WIDTH-1:0]   mem_rd_data;
    logic                    mem_wr_en;
    addr_t                   mem_wr_addr;
    logic [DATA_WIDTH-1:0]   mem_wr_data;
    logic [DATA_WIDTH/8-1:0] mem_wr_strb;

    assign arready = !rd_full;
    assign awready = !wr_full;

    //----------------------------------------------------------------------
    // Outstanding command queues
    //----------------------------------------------------------------------
    axi_cmd_fifo #(.WIDTH(CMD_W), .DEPTH(ACAPA)) u_rd_cmd_fifo (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .push      (arvalid && arready),
        .push_data ({arburst, araddr, arlen, arid}),
        .pop       (rd_pop),
        .head      (rd_head),
        .full      (rd_full),
        .empty     (rd_empty)
    );

    axi_cmd_fifo #(.WIDTH(CMD_W), .DEPTH(ACAPA)) u_wr_cmd_fifo (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .push      (awvalid && awready),
        .push_data ({awburst, awaddr, awlen, awid}),
        .pop       (wr_pop),
        .head      (wr_head),
        .full      (wr_full),
        .empty     (wr_empty)
    );

    //----------------------------------------------------------------------
    // Data channels and storage
    //----------------------------------------------------------------------
    axi_read_channel #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) u_rd_chan (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .rd_bus_hold (rd_bus_hold),
        .cmd_empty   (rd_empty),
        .cmd_addr    (rd_head[ADDR_LSB +: ADDR_WIDTH]),
        .cmd_len     (rd_head[LEN_LSB +: $bits(len_t)]),
        .cmd_burst   (burst_e'(rd_head[BURST_LSB +: $bits(burst_e)])),
        .cmd_id      (rd_head[ID_WIDTH-1:0]),
        .cmd_pop     (rd_pop),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data),
        .rready      (rready),
        .rvalid      (rvalid),
        .rid         (rid),
        .rdata       (rdata),
        .rlast       (rlast),
        .rresp       (rresp)
    );

    axi_write_channel #(
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH),
        .ACAPA      (ACAPA)
    ) u_wr_chan (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .wr_bus_hold (wr_bus_hold),
        .br_bus_hold (br_bus_hold),
        .cmd_empty   (wr_empty),
        .cmd_addr    (wr_head[ADDR_LSB +: ADDR_WIDTH]),
        .cmd_len     (wr_head[LEN_LSB +: $bits(len_t)]),
        .cmd_burst   (burst_e'(wr_head[BURST_LSB +: $bits(burst_e)])),
        .cmd_id      (wr_head[ID_WIDTH-1:0]),
        .cmd_pop     (wr_pop),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .mem_wr_strb (mem_wr_strb),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wlast       (wlast),
        .wready      (wready),
        .bready      (bready),
        .bvalid      (bvalid),
        .bid         (bid),
        .bresp       (bresp)
    );

    axi_mem_array #(.DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)) u_mem (
        .ACLK    (ACLK),
        .rd_addr (mem_rd_addr),
        .rd_data (mem_rd_data),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .wr_strb (mem_wr_strb)
    );

endmodule

/* tb_axi_slave_mem_properties.sv */
`timescale 1ns/1ps

module tb_axi_slave_mem_properties #(
    parameter int DATA_WIDTH = 128,
    parameter int ID_WIDTH   = 8
) (
    input logic                  ACLK,
    input logic                  ARESETn,
    input logic                  rvalid,
    input logic                  rready,
    input logic [ID_WIDTH-1:0]   rid,
    input logic [DATA_WIDTH-1:0] rdata,
    input logic                  rlast,
    input logic                  wvalid,
    input logic                  wready,
    input logic                  bvalid,
    input logic                  bready,
    input logic [ID_WIDTH-1:0]   bid
);

    // A stalled R beat keeps its ID and last flag
    r_hold_a: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (rvalid && !rready) |=> !rvalid || ($stable(rid) && $stable(rlast)))
        else $error("R channel ID or last flag changed while stalled");

    // Data only moves if the stalled cycle also wrote memory
    r_data_a: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (rvalid && !rready && !(wvalid && wready)) |=> !rvalid || $stable(rdata))
        else $error("R channel data changed while stalled");

    b_hold_a: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (bvalid && !bready) |=> !bvalid || $stable(bid))
        else $error("B channel ID changed while stalled");

    reset_a: assert property (@(posedge ACLK) !ARESETn |-> !rvalid && !wready && !bvalid)
        else $error("Valid or ready output high during reset");

endmodule

bind axi_slave_mem tb_axi_slave_mem_properties #(
    .DATA_WIDTH (DATA_WIDTH),
    .ID_WIDTH   (ID_WIDTH)
) u_props (.*);

/* tb_axi_slave_mem.sv */
`timescale 1ns/1ps

module tb_axi_slave_mem;

    import axi_mem_pkg::*;

    localparam int DW          = 128;
    localparam int IDW         = 8;
    localparam int BEAT_BYTES  = DW / 8;
    localparam int WORDS       = 256;
    localparam int TOTAL_BEATS = 64 + 144 + 20 + 64;

    typedef struct packed {
        logic [IDW-1:0] id;
        burst_e         burst;
        addr_t          addr;
        len_t           len;
    } cmd_t;

    logic ACLK = 1'b0;
    logic ARESETn;
    logic rd_bus_hold, wr_bus_hold, br_bus_hold;
    logic arready, arvalid, rready, rvalid, rlast;
    logic awready, awvalid, wready, wvalid, wlast;
    logic bready, bvalid;
    logic [IDW-1:0] arid, rid, awid, bid;
    addr_t   araddr, awaddr;
    len_t    arlen, awlen;
    burst_e  arburst, awburst;
    resp_t   rresp, bresp;
    logic [DW-1:0]   rdata, wdata;
    logic [DW/8-1:0] wstrb;

    word_t          shadow [WORDS];
    cmd_t           ar_q[$];
    cmd_t           aw_q[$];
    logic [IDW-1:0] b_q[$];
    len_t           rd_beat = '0;
    len_t           wr_beat = '0;
    logic [15:0]    lfsr = 16'd48890;
    logic           hold_mode = 1'b0;
    string          cur_test = "reset";
    int             err_data = 0;
    int             err_resp = 0;
    int             err_other = 0;

    axi_slave_mem #(
        .DATA_WIDTH (DW),
        .ID_WIDTH   (IDW),
        .ACAPA      (4),
        .MEM_WORDS  (WORDS)
    ) DUT (.*);

    always #50 ACLK = ~ACLK;

    //----------------------------------------------------------------------
    // Random source and reference model
    //----------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);   // Galois step
        end
        return v;
    endfunction

    function automatic addr_t ref_beat_addr(input addr_t addr, input len_t len,
                                            input burst_e burst, input len_t beat);
        addr_t aligned;
        addr_t win;
        addr_t base;
        aligned = addr & ~addr_t'(BEAT_BYTES - 1);
        if (burst == BURST_INCR) begin
            return aligned + 32'(beat) * BEAT_BYTES;
        end
        if (burst == BURST_WRAP && (len == 1 || len == 3 || len == 7 || len == 15)) begin
            win  = (32'(len) + 1) * BEAT_BYTES;
            base = aligned - (aligned % win);
            return base + ((aligned - base) + 32'(beat) * BEAT_BYTES) % win;
        end
        return aligned;                                 // FIXED, reserved, odd WRAP
    endfunction

    function automatic logic [DW-1:0] expected_beat(input addr_t baddr);
        logic [DW-1:0] v;
        for (int k = 0; k < DW / 32; k++) begin
            v[k*32 +: 32] = shadow[(baddr / 4 + k) % WORDS];
        end
        return v;
    endfunction

    function automatic void shadow_write(input addr_t baddr, input logic [DW-1:0] d,
                                         input logic [DW/8-1:0] s);
        for (int j = 0; j < DW / 8; j++) begin
            if (s[j]) begin
                shadow[(baddr / 4 + j / 4) % WORDS][(j % 4)*8 +: 8] = d[j*8 +: 8];
            end
        end
    endfunction

    //----------------------------------------------------------------------
    // Comparison at the rising edge
    //----------------------------------------------------------------------
    always @(posedge ACLK) begin
        cmd_t          c;
        addr_t         ba;
        logic [DW-1:0] exp_d;
        if (ARESETn) begin
            if (rvalid && rready) begin
                if (ar_q.size() == 0) begin
                    $display("%s: read beat with no read command outstanding", cur_test);
                    err_other++;
                end else begin
                    c     = ar_q[0];
                    ba    = ref_beat_addr(c.addr, c.len, c.burst, rd_beat);
                    exp_d = expected_beat(ba);
                    if (rdata !== exp_d) begin
                        $display("FAILED %s rdata expected %h actual %h", cur_test, exp_d, rdata);
                        err_data++;
                    end
                    if (rid !== c.id || rresp !== RESP_OKAY) begin
                        $display("FAILED %s rid/rresp expected %h/%h actual %h/%h",
                                 cur_test, c.id, RESP_OKAY, rid, rresp);
                        err_resp++;
                    end
                    if (rlast !== (rd_beat == c.len)) begin
                        $display("FAILED %s rlast expected %b actual %b",
                                 cur_test, rd_beat == c.len, rlast);
                        err_resp++;
                    end
                    if (rd_beat == c.len) begin
                        void'(ar_q.pop_front());
                        rd_beat = '0;
                    end else begin
                        rd_beat++;
                    end
                end
            end
            if (wvalid && wready) begin       // Applied after the read check like the memory
                if (aw_q.size() == 0) begin
                    $display("%s: write beat with no write command outstanding", cur_test);
                    err_other++;
                end else begin
                    c = aw_q[0];
                    shadow_write(ref_beat_addr(c.addr, c.len, c.burst, wr_beat), wdata, wstrb);
                    if (wlast) begin
                        b_q.push_back(c.id);
                        void'(aw_q.pop_front());
                        wr_beat = '0;
                    end else if (wr_beat != c.len) begin
                        wr_beat++;
                    end
                end
            end
            if (bvalid && bready) begin
                if (b_q.size() == 0) begin
                    $display("%s: write response with no write burst completed", cur_test);
                    err_other++;
                end else begin
                    if (bid !== b_q[0] || bresp !== RESP_OKAY) begin
                        $display("FAILED %s bid/bresp expected %h/%h actual %h/%h",
                                 cur_test, b_q[0], RESP_OKAY, bid, bresp);
                        err_resp++;
                    end
                    void'(b_q.pop_front());
                end
            end
            if (arvalid && arready) ar_q.push_back('{arid, arburst, araddr, arlen});
            if (awvalid && awready) aw_q.push_back('{awid, awburst, awaddr, awlen});
        end
    end

    // Random back-pressure
    always @(posedge ACLK) begin
        #1;
        if (hold_mode) begin
            rd_bus_hold = (rand_bits(2) == 0);
            wr_bus_hold = (rand_bits(2) == 0);
            br_bus_hold = (rand_bits(2) == 0);
            rready      = (rand_bits(2) != 0);
            bready      = (rand_bits(2) != 0);
        end
    end

    //----------------------------------------------------------------------
    // Master tasks
    //----------------------------------------------------------------------
    task automatic send_write(input logic [IDW-1:0] id, input addr_t addr,
                              input len_t len, input burst_e burst);
        awvalid = 1'b1;
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awburst = burst;
        @(posedge ACLK);
        while (!awready) @(posedge ACLK);
        #1 awvalid = 1'b0;
        for (int b = 0; b <= len; b++) begin
            wvalid = 1'b1;
            wdata  = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
            wstrb  = (DW/8)'(rand_bits(DW / 8));
            wlast  = (b == len);
            @(posedge ACLK);
            while (!wready) @(posedge ACLK);
            #1;
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic send_read(input logic [IDW-1:0] id, input addr_t addr,
                             input len_t len, input burst_e burst);
        arvalid = 1'b1;
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arburst = burst;
        @(posedge ACLK);
        while (!arready) @(posedge ACLK);
        #1 arvalid = 1'b0;
    endtask

    task automatic wait_idle();
        while (ar_q.size() != 0 || aw_q.size() != 0 || b_q.size() != 0) begin
            @(posedge ACLK);
        end
        #1;
    endtask

    // Watchdog
    initial begin
        repeat (TOTAL_BEATS * 20) @(posedge ACLK);
        $display("Watchdog timeout in %s: the DUT stopped responding", cur_test);
        $display("Test failed");
        $finish;
    end

    initial begin
        addr_t  a;
        burst_e bt;
        len_t   lens [5] = '{4'd1, 4'd3, 4'd7, 4'd15, 4'd5};
        for (int i = 0; i < WORDS; i++) shadow[i] = '0;
        ARESETn = 1'b0;
        {rd_bus_hold, wr_bus_hold, br_bus_hold} = '0;
        {arvalid, awvalid, wvalid, wlast} = '0;
        rready = 1'b1;
        bready = 1'b1;
        {arid, awid, araddr, awaddr, arlen, awlen} = '0;
        arburst = BURST_INCR;
        awburst = BURST_INCR;
        wdata   = '0;
        wstrb   = '0;
        repeat (10) @(posedge ACLK);
        #1 ARESETn = 1'b1;

        cur_test = "reset_values";
        if (arready !== 1'b1 || awready !== 1'b1 || rvalid !== 1'b0 ||
            wready !== 1'b0 || bvalid !== 1'b0) begin
            $display("%s: handshake outputs wrong after reset", cur_test);
            err_other++;
        end

        cur_test = "incr_bursts";
        for (int i = 0; i < 4; i++) send_write(IDW'(i), 32'h100 + i * 128, 4'd7, BURST_INCR);
        for (int i = 0; i < 4; i++) send_read(IDW'(16 + i), 32'h100 + i * 128, 4'd7, BURST_INCR);
        wait_idle();

        cur_test = "fixed_wrap_bursts";
        for (int t = 0; t < 2; t++) begin
            bt = (t == 0) ? BURST_FIXED : BURST_WRAP;
            foreach (lens[i]) begin
                a = rand_bits(12);
                send_write(IDW'(32 + i), a, lens[i], bt);
                send_read(IDW'(48 + i), a, lens[i], bt);
                wait_idle();
            end
        end

        cur_test = "read_queue_full";
        rready = 1'b0;
        for (int i = 0; i < 4; i++) send_read(IDW'(64 + i), rand_bits(12), 4'd3, BURST_INCR);
        if (arready !== 1'b0) begin
            $display("%s: arready still high with four reads queued", cur_test);
            err_other++;
        end
        fork
            send_read(IDW'(68), rand_bits(12), 4'd3, BURST_INCR);
            begin
                repeat (3) @(posedge ACLK);
                #1 rready = 1'b1;
            end
        join
        wait_idle();

        cur_test = "random_holds";
        hold_mode = 1'b1;
        fork
            for (int i = 0; i < 8; i++) send_write(IDW'(80 + i), rand_bits(12), 4'd3, BURST_INCR);
            for (int i = 0; i < 8; i++) send_read(IDW'(96 + i), rand_bits(12), 4'd3, BURST_WRAP);
        join
        wait_idle();
        hold_mode = 1'b0;
        {rd_bus_hold, wr_bus_hold, br_bus_hold} = '0;
        rready = 1'b1;
        bready = 1'b1;
        wait_idle();

        $display("Errors: data %0d, response %0d, other %0d", err_data, err_resp, err_other);
        if (err_data + err_resp + err_other == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* list.f */
axi_mem_pkg.sv
axi_cmd_fifo.sv
axi_burst_addr.sv
axi_mem_array.sv
axi_read_channel.sv
axi_write_channel.sv
axi_slave_mem.sv
tb_axi_slave_mem_properties.sv
tb_axi_slave_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axi_slave_mem
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
